//--- rtl/qTable_defs.svh
`ifndef QTABLE_DEFS_SVH
`define QTABLE_DEFS_SVH

// every packet field and table field
`define WORD_WIDTH 16

// table regions, neighbor records first, then cluster-head slots
`define MAX_NEIGHBORS 16
`define MAX_CH 8

`define TABLE_DEPTH (`MAX_NEIGHBORS + `MAX_CH) // total memory words
`define ADDR_WIDTH 5 // enough for TABLE_DEPTH

`endif

//--- rtl/qTablePkg.sv
`include "qTable_defs.svh"

package qTablePkg;

    typedef logic [`WORD_WIDTH-1:0] field_t; // one table field

    // neighbor record as stored in the low region
    typedef struct packed {
        field_t id;
        field_t hops;
        field_t clusterId;
        field_t energy;
        field_t qValue;
    } neighborRec_t;

    // cluster-head slot, id in the top field
    typedef struct packed {
        field_t chId;
        field_t [3:0] rsvd; // pad to record width, written as zero
    } chRec_t;

    // one memory word, view picked by address region
    typedef union packed {
        neighborRec_t nbr; // below MAX_NEIGHBORS
        chRec_t ch;        // MAX_NEIGHBORS and up
    } tableWord_u;

    typedef logic [`ADDR_WIDTH-1:0] tableAddr_t;

endpackage

//--- rtl/tableBus.sv
// one engine's port onto the shared table
interface tableBus
    import qTablePkg::*;
();
    logic req;         // access pending
    tableAddr_t addr;
    logic we;          // write when set, else read
    tableWord_u wdata;
    logic gnt;         // access happens in this cycle
    tableWord_u rdata; // valid the cycle after a read grant

    modport requester (
        output req,
        output addr,
        output we,
        output wdata,
        input gnt,
        input rdata
    );

    modport arbiter (
        input req,
        input addr,
        input we,
        input wdata,
        output gnt,
        output rdata
    );

endinterface

//--- rtl/tableArbiter.sv
`include "qTable_defs.svh"

module tableArbiter
    import qTablePkg::*;
(
    input logic clk,
    input logic nrst,
    tableBus.arbiter nbrBus,
    tableBus.arbiter chBus
);
    tableWord_u mem [`TABLE_DEPTH]; // neighbor region then ch region
    logic lastCh;                  // previous grant went to ch engine
    logic nbrGnt;
    logic chGnt;
    tableAddr_t addr;              // muxed access
    logic we;
    tableWord_u wdata;
    tableWord_u rdataQ;            // registered read port

    // round robin where the side not served last wins a tie
    assign nbrGnt = nbrBus.req && (!chBus.req || lastCh);
    assign chGnt = chBus.req && (!nbrBus.req || !lastCh);

    assign nbrBus.gnt = nbrGnt;
    assign chBus.gnt = chGnt;

    always_comb begin
        if (chGnt) begin
            addr = chBus.addr;
            we = chBus.we;
            wdata = chBus.wdata;
        end else begin
            addr = nbrBus.addr; // also the idle default
            we = nbrBus.we && nbrGnt;
            wdata = nbrBus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            lastCh <= 1'b0; // ch engine gets the first tie
        end else if (nbrGnt || chGnt) begin
            lastCh <= chGnt;
        end
    end

    // single port that writes in the grant cycle and reads one cycle later
    always_ff @(posedge clk) begin
        if (nbrGnt || chGnt) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdataQ <= mem[addr]; // old contents on a write and not sampled
        end
    end

    // only the engine granted last cycle samples this
    assign nbrBus.rdata = rdataQ;
    assign chBus.rdata = rdataQ;

    // a turned-away request wins the next cycle so neither side starves
    assert property (@(posedge clk) disable iff (!nrst)
        (nbrBus.req && !nbrGnt) |=> nbrGnt);

    assert property (@(posedge clk) disable iff (!nrst)
        (chBus.req && !chGnt) |=> chGnt);

endmodule

//--- rtl/neighborUpdater.sv
`include "qTable_defs.svh"

module neighborUpdater
    import qTablePkg::*;
(
    input logic clk,
    input logic nrst,
    input logic start,
    input neighborRec_t pkt,
    tableBus.requester bus,
    output logic finished,
    output logic found,
    output field_t prevQ,
    output field_t count
);
    typedef enum logic [2:0] {
        sIdle,
        sCheck,   // end of list reached?
        sRead,    // fetch record idx
        sCompare, // stored id against packet id
        sWrite,   // update in place or append
        sDone
    } state_t;

    state_t state;
    field_t idx;           // scan position, later the write slot
    field_t storedHops;    // hops of the matched record, kept on update
    neighborRec_t stored;  // read word through the neighbor view
    tableWord_u wrWord;
    logic idMatch;

    assign stored = bus.rdata.nbr;
    assign idMatch = (stored.id == pkt.id);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= sIdle;
            idx <= '0;
            found <= 1'b0;
            count <= '0; // table starts empty
        end else begin
            case (state)
                sIdle, sDone: begin
                    if (start) begin
                        state <= sCheck;
                        idx <= '0;
                        found <= 1'b0;
                    end
                end
                sCheck: begin
                    if (idx == count) begin
                        // not in table, append if room
                        state <= (count < `MAX_NEIGHBORS) ? sWrite : sDone;
                    end else begin
                        state <= sRead;
                    end
                end
                sRead: begin
                    if (bus.gnt) state <= sCompare; // rdata valid next cycle
                end
                sCompare: begin
                    if (idMatch) begin
                        found <= 1'b1; // idx stays on the hit
                        state <= sWrite;
                    end else begin
                        idx <= idx + 16'd1;
                        state <= sCheck;
                    end
                end
                sWrite: begin
                    if (bus.gnt) begin
                        if (!found) count <= count + 16'd1; // append grew the list
                        state <= sDone;
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    // previous Q of the record, zero when it was new
    always_ff @(posedge clk) begin
        if ((state == sIdle || state == sDone) && start) begin
            prevQ <= '0;
        end else if (state == sCompare && idMatch) begin
            prevQ <= stored.qValue;
            storedHops <= stored.hops;
        end
    end

    always_comb begin
        wrWord.nbr = pkt; // full record for an append
        if (found) wrWord.nbr.hops = storedHops; // update keeps the old hops
    end

    assign bus.req = (state == sRead) || (state == sWrite);
    assign bus.we = (state == sWrite);
    assign bus.addr = idx[`ADDR_WIDTH-1:0]; // neighbor region starts at 0
    assign bus.wdata = wrWord;
    assign finished = (state == sDone); // level until the next start

    // append is skipped once the region is full
    assert property (@(posedge clk) disable iff (!nrst) count <= `MAX_NEIGHBORS);

endmodule

//--- rtl/clusterHeadTracker.sv
`include "qTable_defs.svh"

module clusterHeadTracker
    import qTablePkg::*;
(
    input logic clk,
    input logic nrst,
    input logic start,
    input field_t chId,
    tableBus.requester bus,
    output logic finished,
    output logic added,
    output field_t count
);
    typedef enum logic [2:0] {
        sIdle,
        sCheck,
        sRead,
        sCompare,
        sWrite, // append only, a hit needs no write
        sDone
    } state_t;

    state_t state;
    field_t idx;  // slot being scanned
    tableWord_u wrWord;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= sIdle;
            idx <= '0;
            added <= 1'b0;
            count <= '0;
        end else begin
            case (state)
                sIdle, sDone: begin
                    if (start) begin
                        state <= sCheck;
                        idx <= '0;
                        added <= 1'b0;
                    end
                end
                sCheck: begin
                    if (idx == count) begin
                        state <= (count < `MAX_CH) ? sWrite : sDone; // full list drops it
                    end else begin
                        state <= sRead;
                    end
                end
                sRead: begin
                    if (bus.gnt) state <= sCompare;
                end
                sCompare: begin
                    // decode through the ch view of the word
                    if (bus.rdata.ch.chId == chId) begin
                        state <= sDone; // already known
                    end else begin
                        idx <= idx + 16'd1;
                        state <= sCheck;
                    end
                end
                sWrite: begin
                    if (bus.gnt) begin
                        added <= 1'b1;
                        count <= count + 16'd1;
                        state <= sDone;
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    always_comb begin
        wrWord.ch.chId = chId;
        wrWord.ch.rsvd = '0;
    end

    assign bus.req = (state == sRead) || (state == sWrite);
    assign bus.we = (state == sWrite);
    // ch slots sit above the neighbor records
    assign bus.addr = tableAddr_t'(`MAX_NEIGHBORS) + idx[`ADDR_WIDTH-1:0];
    assign bus.wdata = wrWord;
    assign finished = (state == sDone);

    assert property (@(posedge clk) disable iff (!nrst) count <= `MAX_CH);

endmodule

//--- rtl/qTableUpdate.sv
`include "qTable_defs.svh"

module qTableUpdate
    import qTablePkg::*;
(
    input logic clk,
    input logic nrst,
    input logic en,
    input logic [`WORD_WIDTH-1:0] fSourceId,
    input logic [`WORD_WIDTH-1:0] fSourceHops,
    input logic [`WORD_WIDTH-1:0] fClusterId,
    input logic [`WORD_WIDTH-1:0] fEnergyLeft,
    input logic [`WORD_WIDTH-1:0] fQValue,
    input logic [`WORD_WIDTH-1:0] fKnownCh,
    output logic busy,
    output logic done,
    output logic nodeFound,
    output logic [`WORD_WIDTH-1:0] prevQValue,
    output logic chAdded,
    output logic [`WORD_WIDTH-1:0] neighborCount,
    output logic [`WORD_WIDTH-1:0] knownChCount
);
    tableBus nbrBus ();
    tableBus chBus ();

    neighborRec_t pktQ; // latched packet
    field_t chIdQ;
    logic start;
    logic allFinished;
    logic nbrFin, chFin;
    logic nbrFound, chAddedNow;
    field_t nbrPrevQ, nbrCount, chCount;

    assign start = en && !busy; // en during an update is dropped
    assign allFinished = busy && nbrFin && chFin;

    always_ff @(posedge clk) begin
        if (start) begin
            pktQ.id <= fSourceId;
            pktQ.hops <= fSourceHops;
            pktQ.clusterId <= fClusterId;
            pktQ.energy <= fEnergyLeft;
            pktQ.qValue <= fQValue;
            chIdQ <= fKnownCh;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            busy <= 1'b0;
            done <= 1'b0;
            nodeFound <= 1'b0;
            prevQValue <= '0;
            chAdded <= 1'b0;
            neighborCount <= '0;
            knownChCount <= '0;
        end else begin
            done <= allFinished; // single pulse, busy drops with it
            if (start) busy <= 1'b1;
            else if (allFinished) busy <= 1'b0;
            if (allFinished) begin
                // results held until the next done
                nodeFound <= nbrFound;
                prevQValue <= nbrPrevQ;
                chAdded <= chAddedNow;
                neighborCount <= nbrCount;
                knownChCount <= chCount;
            end
        end
    end

    neighborUpdater u_nbr (
        .clk(clk),
        .nrst(nrst),
        .start(start),
        .pkt(pktQ),
        .bus(nbrBus.requester),
        .finished(nbrFin),
        .found(nbrFound),
        .prevQ(nbrPrevQ),
        .count(nbrCount)
    );

    clusterHeadTracker u_ch (
        .clk(clk),
        .nrst(nrst),
        .start(start),
        .chId(chIdQ),
        .bus(chBus.requester),
        .finished(chFin),
        .added(chAddedNow),
        .count(chCount)
    );

    tableArbiter u_arb (
        .clk(clk),
        .nrst(nrst),
        .nbrBus(nbrBus.arbiter),
        .chBus(chBus.arbiter)
    );

endmodule

//--- verification/clockGen.sv
module clockGen #(
    parameter int period = 100,
    parameter int resetCycles = 16
) (
    output logic clk,
    output logic nrst
);
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        nrst = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #10 nrst = 1'b1; // released off the edge like the other inputs
    end
endmodule

//--- verification/qTableUpdateTb.sv
`include "qTable_defs.svh"

module qTableUpdateTb
    import qTablePkg::*;
();
    localparam int numRandom = 40;
    localparam int numFill = 16;                   // distinct ids that also overrun the ch slots
    localparam int numPackets = numRandom + numFill + 4; // full-table pair and busy pair
    localparam int updateCycles = 100;             // budget per packet, far above a full scan
    localparam int cycleLimit = 16 + updateCycles * numPackets;

    typedef struct packed {
        logic found;
        field_t prevQ;
        logic added;
        field_t nbrCount;
        field_t chCount;
    } expect_t;

    logic clk;
    logic nrst;
    logic en;
    field_t fSourceId;
    field_t fSourceHops;
    field_t fClusterId;
    field_t fEnergyLeft;
    field_t fQValue;
    field_t fKnownCh;
    logic busy;
    logic done;
    logic nodeFound;
    field_t prevQValue;
    logic chAdded;
    field_t neighborCount;
    field_t knownChCount;

    // reference state
    field_t refId [`MAX_NEIGHBORS];
    field_t refQ [`MAX_NEIGHBORS];
    field_t refCh [`MAX_CH];
    int refNbrCount = 0;
    int refChCount = 0;
    expect_t expQ [$];                             // one entry per accepted packet

    int seed;
    int errorCount = 0;
    int checkCount = 0;
    int doneCount = 0;
    int donesWanted = 0;
    int cycleCount = 0;

    clockGen u_clk (.clk(clk), .nrst(nrst));

    qTableUpdate u_dut (
        .clk(clk),
        .nrst(nrst),
        .en(en),
        .fSourceId(fSourceId),
        .fSourceHops(fSourceHops),
        .fClusterId(fClusterId),
        .fEnergyLeft(fEnergyLeft),
        .fQValue(fQValue),
        .fKnownCh(fKnownCh),
        .busy(busy),
        .done(done),
        .nodeFound(nodeFound),
        .prevQValue(prevQValue),
        .chAdded(chAdded),
        .neighborCount(neighborCount),
        .knownChCount(knownChCount)
    );

    // expected outputs for one packet with the model state updated in place
    function automatic expect_t predictResult(input field_t id, input field_t q, input field_t ch);
        expect_t r;
        int hit;
        int i;
        logic chKnown;
        r = '0;
        hit = -1;
        chKnown = 1'b0;
        for (i = 0; i < refNbrCount; i++) begin
            if (hit < 0 && refId[i] == id) hit = i;
        end
        if (hit >= 0) begin
            r.found = 1'b1;
            r.prevQ = refQ[hit];
            refQ[hit] = q;                         // hops etc. not visible at the ports
        end else if (refNbrCount < `MAX_NEIGHBORS) begin
            refId[refNbrCount] = id;
            refQ[refNbrCount] = q;
            refNbrCount++;
        end                                        // full table drops the new id
        for (i = 0; i < refChCount; i++) begin
            if (refCh[i] == ch) chKnown = 1'b1;
        end
        if (!chKnown && refChCount < `MAX_CH) begin
            refCh[refChCount] = ch;
            refChCount++;
            r.added = 1'b1;
        end
        r.nbrCount = field_t'(refNbrCount);
        r.chCount = field_t'(refChCount);
        return r;
    endfunction

    task automatic compareValue(input string name, input field_t expected, input field_t actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic driveFields(input field_t id, input field_t ch, input field_t q);
        fSourceId = id;
        fSourceHops = field_t'($random(seed));
        fClusterId = field_t'($random(seed));
        fEnergyLeft = field_t'($random(seed));
        fQValue = q;
        fKnownCh = ch;
    endtask

    // one en pulse with its expectation queued for the compare process
    task automatic startPacket(input field_t id, input field_t ch);
        field_t q;
        q = field_t'($random(seed));
        @(posedge clk);
        #10;
        driveFields(id, ch, q);
        expQ.push_back(predictResult(id, q, ch));
        donesWanted++;
        en = 1'b1;
        @(posedge clk);
        #10;
        en = 1'b0;
    endtask

    task automatic sendPacket(input field_t id, input field_t ch);
        startPacket(id, ch);
        wait (doneCount >= donesWanted);
    endtask

    // results checked half a cycle after done rises
    always @(negedge clk) begin
        expect_t e;
        if (nrst && done) begin
            doneCount++;
            checkCount++;
            assert (expQ.size() > 0) else begin
                errorCount++;
                $display("done pulse at %0t with no packet pending", $time);
            end
            if (expQ.size() > 0) begin
                e = expQ.pop_front();
                compareValue("nodeFound", field_t'(e.found), field_t'(nodeFound));
                compareValue("prevQValue", e.prevQ, prevQValue);
                compareValue("chAdded", field_t'(e.added), field_t'(chAdded));
                compareValue("neighborCount", e.nbrCount, neighborCount);
                compareValue("knownChCount", e.chCount, knownChCount);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout, run still going after %0d cycles", cycleCount);
            $display("checks %0d, errors %0d", checkCount, errorCount);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        field_t id;
        field_t ch;
        field_t firstId;
        int k;
        seed = 32'h6bed;
        en = 1'b0;
        fSourceId = '0;
        fSourceHops = '0;
        fClusterId = '0;
        fEnergyLeft = '0;
        fQValue = '0;
        fKnownCh = '0;
        wait (nrst);
        @(negedge clk);
        compareValue("busy", '0, field_t'(busy)); // idle after reset
        compareValue("done", '0, field_t'(done));
        compareValue("neighborCount", '0, neighborCount);
        compareValue("knownChCount", '0, knownChCount);
        firstId = '0;
        for (k = 0; k < numRandom; k++) begin
            id = field_t'($unsigned($random(seed)) % 24); // small range so ids repeat
            ch = field_t'($unsigned($random(seed)) % 12);
            if (k == 0) firstId = id;
            sendPacket(id, ch);
        end
        for (k = 0; k < numFill; k++) begin
            sendPacket(field_t'(16'h1000 + k), field_t'(16'h2000 + k));
        end
        compareValue("neighborCount", field_t'(`MAX_NEIGHBORS), neighborCount);
        compareValue("knownChCount", field_t'(`MAX_CH), knownChCount);
        // new id twice on a full table and never stored
        sendPacket(16'h3000, 16'h4000);
        sendPacket(16'h3000, 16'h4000);
        compareValue("nodeFound", '0, field_t'(nodeFound));
        compareValue("chAdded", '0, field_t'(chAdded));
        compareValue("neighborCount", field_t'(`MAX_NEIGHBORS), neighborCount);
        // second en while busy must be dropped
        startPacket(firstId, 16'h2001);
        @(posedge clk);
        #10;
        checkCount++;
        assert (busy) else begin
            errorCount++;
            $display("busy was low when the second en was given at %0t", $time);
        end
        driveFields(16'h3000, 16'h4002, 16'hbeef);
        en = 1'b1;
        @(posedge clk);
        #10;
        en = 1'b0;
        wait (doneCount >= donesWanted);
        // a wrongly started second update would finish inside one budget
        repeat (updateCycles) @(posedge clk);
        checkCount++;
        assert (doneCount == donesWanted) else begin
            errorCount++;
            $display("an extra done followed the en given while busy");
        end
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end
endmodule

//--- qTableUpdate.f
+incdir+rtl
rtl/qTablePkg.sv
rtl/tableBus.sv
rtl/tableArbiter.sv
rtl/neighborUpdater.sv
rtl/clusterHeadTracker.sv
rtl/qTableUpdate.sv
verification/clockGen.sv
verification/qTableUpdateTb.sv

//--- Makefile
TOP = qTableUpdateTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f qTableUpdate.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir
